// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_front
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
front_pkg.sv
fs_ds_if.sv
pc_gen.sv
if_stage.sv
id_stage.sv
front_top.sv
tb_front.sv

// File: front_pkg.sv
// front end shared definitions
`default_nettype none

package front_pkg;

  localparam int PC_WD        = 32;
  localparam int INST_WD      = 32;
  localparam int SRAM_ADDR_WD = 32;
  // two instructions per sram word
  localparam int SRAM_DATA_WD = 64;

  localparam logic [PC_WD-1:0] PC_RESET_VAL = 32'h8000_0000;

  // rv32i major opcode field, bits 6:0
  localparam logic [6:0] RV_LUI    = 7'b0110111;
  localparam logic [6:0] RV_AUIPC  = 7'b0010111;
  localparam logic [6:0] RV_JAL    = 7'b1101111;
  localparam logic [6:0] RV_JALR   = 7'b1100111;
  localparam logic [6:0] RV_BRANCH = 7'b1100011;
  localparam logic [6:0] RV_LOAD   = 7'b0000011;
  localparam logic [6:0] RV_STORE  = 7'b0100011;
  localparam logic [6:0] RV_OP_IMM = 7'b0010011;
  localparam logic [6:0] RV_OP     = 7'b0110011;
  localparam logic [6:0] RV_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BRANCH,
    OP_LOAD,
    OP_STORE,
    OP_ALUI,
    OP_ALU,
    OP_SYSTEM,
    OP_ILLEGAL
  } opcode_e;

  // redirect from decode back to the pc generator
  typedef struct packed {
    logic             taken;
    logic [PC_WD-1:0] target;
  } br_bus_t;

endpackage

`default_nettype wire

// File: front_tests.txt
// @00 number of expected entries, @10 image words from pc 80000000 upward
// @40 expected entries, one per line: pc inst opcode imm (opcode as enum value)
@00
00000013
@10
123450B7 // 80000000 lui x1, 0x12345
FFFFF117 // 80000004 auipc x2, 0xfffff
FFB00193 // 80000008 addi x3, x0, -5
00208233 // 8000000c add x4, x1, x2
0080A283 // 80000010 lw x5, 8(x1)
FE512E23 // 80000014 sw x5, -4(x2)
00208863 // 80000018 beq x1, x2, 16
00C08067 // 8000001c jalr x0, 12(x1)
00000073 // 80000020 ecall
12345678 // 80000024 illegal, low bits 00
0180006F // 80000028 jal x0, +24
00100313 // 8000002c skipped
00200313 // 80000030 addi x6, x0, 2
00300313 // 80000034 addi x6, x0, 3
0140006F // 80000038 jal x0, +20
00400313 // 8000003c skipped
7FF00393 // 80000040 addi x7, x0, 0x7ff
FEDFF06F // 80000044 jal x0, -20
00500313 // 80000048 skipped
ABCDE437 // 8000004c lui x8, 0xabcde
0000006F // 80000050 jal x0, 0
00600313 // 80000054 skipped
@40
80000000 123450B7 0 12345000
80000004 FFFFF117 1 FFFFF000
80000008 FFB00193 7 FFFFFFFB
8000000C 00208233 8 00000000
80000010 0080A283 5 00000008
80000014 FE512E23 6 FFFFFFFC
80000018 00208863 4 00000010
8000001C 00C08067 3 0000000C
80000020 00000073 9 00000000
80000024 12345678 A 00000000
80000028 0180006F 2 00000018
80000040 7FF00393 7 000007FF
80000044 FEDFF06F 2 FFFFFFEC
80000030 00200313 7 00000002
80000034 00300313 7 00000003
80000038 0140006F 2 00000014
8000004C ABCDE437 0 ABCDE000
80000050 0000006F 2 00000000
80000050 0000006F 2 00000000

// File: front_top.sv
// pipeline front end top
`default_nettype none

module front_top import front_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                    i_es_allowin,
  output logic                    o_ds_to_es_valid,
  output logic [PC_WD-1:0]        o_ds_to_es_pc,
  output logic [INST_WD-1:0]      o_ds_to_es_inst,
  output opcode_e                 o_ds_to_es_opcode,
  output logic [31:0]             o_ds_to_es_imm
);

  fs_ds_if u_fs_ds ();

  br_bus_t br_bus;

  if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_br_bus          (br_bus),
    .fs                (u_fs_ds.fs),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  id_stage u_id_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_es_allowin      (i_es_allowin),
    .ds                (u_fs_ds.ds),
    .o_br_bus          (br_bus),
    .o_ds_to_es_valid  (o_ds_to_es_valid),
    .o_ds_to_es_pc     (o_ds_to_es_pc),
    .o_ds_to_es_inst   (o_ds_to_es_inst),
    .o_ds_to_es_imm    (o_ds_to_es_imm),
    .o_ds_to_es_opcode (o_ds_to_es_opcode)
  );

endmodule

`default_nettype wire

// File: fs_ds_if.sv
// fetch to decode handshake
`default_nettype none

interface fs_ds_if import front_pkg::*; ();

  logic               valid;
  logic               allowin;
  logic [PC_WD-1:0]   pc;
  logic [INST_WD-1:0] inst;

  modport fs (
    output valid,
    output pc,
    output inst,
    input  allowin
  );

  modport ds (
    input  valid,
    input  pc,
    input  inst,
    output allowin
  );

endinterface

`default_nettype wire

// File: id_stage.sv
// instruction decode stage
`default_nettype none

module id_stage import front_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_es_allowin,
  fs_ds_if.ds         ds,
  output br_bus_t     o_br_bus,
  output logic        o_ds_to_es_valid,
  output logic [31:0] o_ds_to_es_pc,
  output logic [31:0] o_ds_to_es_inst,
  output logic [31:0] o_ds_to_es_imm,
  output opcode_e     o_ds_to_es_opcode
);

  logic               ds_valid;
  logic [PC_WD-1:0]   ds_pc;
  logic [INST_WD-1:0] ds_inst;
  opcode_e            opcode;
  logic [31:0]        imm;

  assign ds.allowin = !ds_valid || i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (ds.allowin) begin
      ds_valid <= ds.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ds.allowin && ds.valid) begin
      ds_pc   <= ds.pc;
      ds_inst <= ds.inst;
    end
  end

  // instruction class, compressed encodings are illegal here
  always_comb begin
    if (ds_inst[1:0] != 2'b11) begin
      opcode = OP_ILLEGAL;
    end else begin
      case (ds_inst[6:0])
        RV_LUI:    opcode = OP_LUI;
        RV_AUIPC:  opcode = OP_AUIPC;
        RV_JAL:    opcode = OP_JAL;
        RV_JALR:   opcode = OP_JALR;
        RV_BRANCH: opcode = OP_BRANCH;
        RV_LOAD:   opcode = OP_LOAD;
        RV_STORE:  opcode = OP_STORE;
        RV_OP_IMM: opcode = OP_ALUI;
        RV_OP:     opcode = OP_ALU;
        RV_SYSTEM: opcode = OP_SYSTEM;
        default:   opcode = OP_ILLEGAL;
      endcase
    end
  end

  // sign-extended immediate by format
  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        imm = {ds_inst[31:12], 12'b0};
      end
      OP_JAL: begin
        imm = {{11{ds_inst[31]}}, ds_inst[31], ds_inst[19:12], ds_inst[20],
               ds_inst[30:21], 1'b0};
      end
      OP_BRANCH: begin
        imm = {{19{ds_inst[31]}}, ds_inst[31], ds_inst[7], ds_inst[30:25],
               ds_inst[11:8], 1'b0};
      end
      OP_STORE: begin
        imm = {{20{ds_inst[31]}}, ds_inst[31:25], ds_inst[11:7]};
      end
      OP_JALR, OP_LOAD, OP_ALUI, OP_SYSTEM: begin
        imm = {{20{ds_inst[31]}}, ds_inst[31:20]};
      end
      // r-type and illegal carry no immediate
      default: begin
        imm = 32'b0;
      end
    endcase
  end

  // jal resolved here, only when it actually moves on to execute
  assign o_br_bus.taken  = ds_valid && i_es_allowin && (opcode == OP_JAL);
  assign o_br_bus.target = ds_pc + imm;

  assign o_ds_to_es_valid  = ds_valid;
  assign o_ds_to_es_pc     = ds_pc;
  assign o_ds_to_es_inst   = ds_inst;
  assign o_ds_to_es_imm    = imm;
  assign o_ds_to_es_opcode = opcode;

endmodule

`default_nettype wire

// File: if_stage.sv
// instruction fetch stage
`default_nettype none

module if_stage import front_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  br_bus_t                 i_br_bus,
  fs_ds_if.fs                     fs,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata
);

  logic             to_fs_valid;
  logic             fs_valid;
  logic             fs_allowin;
  logic             fs_load;
  logic [PC_WD-1:0] fs_pc;

  // pre-fetch always has a request once out of reset
  assign to_fs_valid = !i_rst;

  // empty stage, or decode takes what we hold
  assign fs_allowin = !fs_valid || fs.allowin;
  assign fs_load    = to_fs_valid && fs_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_load           (fs_load),
    .i_br_bus         (i_br_bus),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // wrong-path instruction dropped while decode redirects
  assign fs.valid = fs_valid && !i_br_bus.taken;
  assign fs.pc    = fs_pc;

  // pc bit 2 picks the upper half of the 64-bit word
  assign fs.inst = fs_pc[2] ? i_inst_sram_rdata[SRAM_DATA_WD-1:INST_WD]
                            : i_inst_sram_rdata[INST_WD-1:0];

endmodule

`default_nettype wire

// File: pc_gen.sv
// fetch pc generator
`default_nettype none

module pc_gen import front_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_load,
  input  br_bus_t                 i_br_bus,
  output logic [PC_WD-1:0]        o_pc,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [PC_WD-1:0] pc;
  logic [PC_WD-1:0] seq_pc;
  logic [PC_WD-1:0] next_pc;

  assign seq_pc  = pc + PC_WD'(4);
  // redirect from decode wins over the sequential pc
  assign next_pc = i_br_bus.taken ? i_br_bus.target : seq_pc;

  // held one word before the reset pc so the first load lands on it
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= PC_RESET_VAL - PC_WD'(4);
    end else if (i_load) begin
      pc <= next_pc;
    end
  end

  assign o_pc = pc;

  // read issued with the pc about to be loaded
  assign o_inst_sram_ren  = i_load;
  assign o_inst_sram_addr = SRAM_ADDR_WD'({next_pc[PC_WD-1:3], 3'b000});

endmodule

`default_nettype wire

// File: tb_front.sv
// front end testbench
`default_nettype none

module tb_front import front_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS   = 256;
  localparam int IMG_WORDS   = 32;
  localparam int IMG_BASE    = 'h10;
  localparam int EXP_BASE    = 'h40;
  localparam int MAX_EXP     = 32;
  localparam int WAIT_CYCLES = 400;

  bit                      clk;
  logic                    i_rst;
  logic                    es_allowin;
  logic [SRAM_DATA_WD-1:0] sram_rdata;
  logic                    sram_ren;
  logic [SRAM_ADDR_WD-1:0] sram_addr;
  logic                    ds_valid;
  logic [PC_WD-1:0]        ds_pc;
  logic [INST_WD-1:0]      ds_inst;
  opcode_e                 ds_opcode;
  logic [31:0]             ds_imm;

  logic [31:0]        tests_mem [0:MEM_WORDS-1];
  logic [INST_WD-1:0] img [0:IMG_WORDS-1];
  logic [PC_WD-1:0]   exp_pc [0:MAX_EXP-1];
  logic [INST_WD-1:0] exp_inst [0:MAX_EXP-1];
  opcode_e            exp_op [0:MAX_EXP-1];
  logic [31:0]        exp_imm [0:MAX_EXP-1];
  logic [PC_WD-1:0]   act_pc [0:MAX_EXP-1];
  logic [INST_WD-1:0] act_inst [0:MAX_EXP-1];
  opcode_e            act_op [0:MAX_EXP-1];
  logic [31:0]        act_imm [0:MAX_EXP-1];

  int n_exp;
  int n_ret;
  int err_count;
  int tests_passed;
  int tests_failed;
  int stall_cycles;
  bit timed_out;
  bit rd_pending;
  bit jal_held;
  logic [SRAM_ADDR_WD-1:0] rd_addr;

  front_top dut_i (
    .i_clk             (clk),
    .i_rst             (i_rst),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .i_inst_sram_rdata (sram_rdata),
    .i_es_allowin      (es_allowin),
    .o_ds_to_es_valid  (ds_valid),
    .o_ds_to_es_pc     (ds_pc),
    .o_ds_to_es_inst   (ds_inst),
    .o_ds_to_es_opcode (ds_opcode),
    .o_ds_to_es_imm    (ds_imm)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // image word at a byte address or zero outside the image
  function automatic logic [INST_WD-1:0] image_word(input logic [SRAM_ADDR_WD-1:0] a);
    logic [31:0] off;
    off = a - PC_RESET_VAL;
    if (a >= PC_RESET_VAL && off < 32'(IMG_WORDS * 4)) begin
      return img[off[6:2]];
    end
    return '0;
  endfunction

  task automatic check_pc(input int idx, input logic [PC_WD-1:0] e, input logic [PC_WD-1:0] a);
    if (a !== e) begin
      $display("[ERROR] %0d ns entry %0d o_ds_to_es_pc expected %h actual %h", $time, idx, e, a);
      err_count++;
    end
  endtask

  task automatic check_inst(input int idx, input logic [INST_WD-1:0] e,
                            input logic [INST_WD-1:0] a);
    if (a !== e) begin
      $display("[ERROR] %0d ns entry %0d o_ds_to_es_inst expected %h actual %h", $time, idx, e, a);
      err_count++;
    end
  endtask

  task automatic check_opcode(input int idx, input opcode_e e, input opcode_e a);
    if (a !== e) begin
      $display("[ERROR] %0d ns entry %0d o_ds_to_es_opcode expected %s actual %s",
               $time, idx, e.name(), a.name());
      err_count++;
    end
  endtask

  task automatic check_imm(input int idx, input logic [31:0] e, input logic [31:0] a);
    if (a !== e) begin
      $display("[ERROR] %0d ns entry %0d o_ds_to_es_imm expected %h actual %h", $time, idx, e, a);
      err_count++;
    end
  endtask

  task automatic check_level(input string name, input logic e, input logic a);
    if (a !== e) begin
      $display("[ERROR] %0d ns %s expected %b actual %b", $time, name, e, a);
      err_count++;
    end
  endtask

  task automatic load_tests();
    int b;
    for (int i = 0; i < MEM_WORDS; i++) begin
      tests_mem[i] = '0;
    end
    $readmemh("front_tests.txt", tests_mem);
    for (int i = 0; i < IMG_WORDS; i++) begin
      img[i] = tests_mem[IMG_BASE + i];
    end
    n_exp = int'(tests_mem[0]);
    if (n_exp < 1 || n_exp > MAX_EXP) begin
      $display("test data holds an entry count of %0d, which is out of range", n_exp);
      err_count++;
      n_exp = 0;
    end
    for (int k = 0; k < n_exp; k++) begin
      b = EXP_BASE + 4 * k;
      exp_pc[k]   = tests_mem[b];
      exp_inst[k] = tests_mem[b + 1];
      exp_op[k]   = opcode_e'(tests_mem[b + 2][3:0]);
      exp_imm[k]  = tests_mem[b + 3];
    end
  endtask

  task automatic wait_retired(input int count, input string what, output bit ok);
    int cycles;
    cycles = 0;
    while (!timed_out && n_ret < count && cycles < WAIT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    ok = !timed_out && n_ret >= count;
    if (!ok && !timed_out) begin
      $display("timeout: %s never retired within %0d cycles", what, WAIT_CYCLES);
      timed_out = 1'b1;
      err_count++;
    end
  endtask

  task automatic end_test(input string name, input bit ok, input int err_before);
    if (ok && err_count == err_before) begin
      $display("test %s: PASS", name);
      tests_passed++;
    end else begin
      $display("test %s: FAIL", name);
      tests_failed++;
    end
  endtask

  // sram request, retirements and stalls sampled at the falling edge
  always @(negedge clk) begin
    rd_pending = sram_ren;
    rd_addr    = sram_addr;
    if (i_rst) begin
      check_level("o_ds_to_es_valid", 1'b0, ds_valid);
      check_level("o_inst_sram_ren", 1'b0, sram_ren);
    end else if (ds_valid && es_allowin) begin
      if (n_ret < MAX_EXP) begin
        act_pc[n_ret]   = ds_pc;
        act_inst[n_ret] = ds_inst;
        act_op[n_ret]   = ds_opcode;
        act_imm[n_ret]  = ds_imm;
        n_ret++;
      end
    end else if (ds_valid) begin
      // a stalled full pipe issues no new fetch
      stall_cycles++;
      check_level("o_inst_sram_ren", 1'b0, sram_ren);
    end
  end

  // sram answer and back-pressure that holds each jal for at least one cycle
  always @(posedge clk) begin
    #2;
    if (rd_pending) begin
      sram_rdata = {image_word(rd_addr + 32'd4), image_word(rd_addr)};
    end
    if (ds_valid && ds_opcode == OP_JAL && !jal_held) begin
      es_allowin = 1'b0;
      jal_held   = 1'b1;
    end else begin
      es_allowin = ($urandom % 3) != 0;
      if (!ds_valid || ds_opcode != OP_JAL) begin
        jal_held = 1'b0;
      end
    end
  end

  initial begin
    bit               ok;
    int               errs;
    int               first_jal;
    int               fwd;
    int               back;
    logic [PC_WD-1:0] seq_pc;
    void'($urandom(62358));
    i_rst      = 1'b1;
    es_allowin = 1'b1;
    sram_rdata = '0;
    load_tests();
    errs = err_count;
    repeat (3) @(posedge clk);
    #2;
    i_rst = 1'b0;

    wait_retired(1, "first instruction", ok);
    if (ok) begin
      check_pc(0, PC_RESET_VAL, act_pc[0]);
    end
    end_test("1 reset and first fetch", ok, errs);

    first_jal = n_exp;
    for (int k = n_exp - 1; k >= 0; k--) begin
      if (exp_op[k] == OP_JAL) begin
        first_jal = k;
      end
    end

    // pcs step by 4 from reset and words alternate between halves
    errs = err_count;
    wait_retired(first_jal, "sequential block", ok);
    if (ok) begin
      for (int k = 0; k < first_jal; k++) begin
        seq_pc = PC_RESET_VAL + PC_WD'(4 * k);
        check_pc(k, seq_pc, act_pc[k]);
        check_inst(k, image_word(seq_pc), act_inst[k]);
      end
    end
    end_test("2 sequential fetch", ok, errs);

    errs = err_count;
    wait_retired(first_jal, "sequential block", ok);
    if (ok) begin
      for (int k = 0; k < first_jal; k++) begin
        check_opcode(k, exp_op[k], act_op[k]);
        check_imm(k, exp_imm[k], act_imm[k]);
      end
    end
    end_test("3 decode", ok, errs);

    // next retired pc after each jal is pc plus its immediate
    errs = err_count;
    fwd  = 0;
    back = 0;
    wait_retired(n_exp, "jump sequence", ok);
    if (ok) begin
      for (int k = 0; k + 1 < n_exp; k++) begin
        if (exp_op[k] == OP_JAL) begin
          seq_pc = exp_pc[k] + exp_imm[k];
          check_pc(k + 1, seq_pc, act_pc[k + 1]);
          check_inst(k + 1, image_word(seq_pc), act_inst[k + 1]);
          if (exp_imm[k][31]) begin
            back++;
          end else begin
            fwd++;
          end
        end
      end
      if (fwd == 0 || back == 0) begin
        $display("test data lacks a forward or a backward jump");
        err_count++;
      end
    end
    end_test("4 jal redirect", ok, errs);

    errs = err_count;
    wait_retired(n_exp, "full sequence", ok);
    if (ok) begin
      for (int k = 0; k < n_exp; k++) begin
        check_pc(k, exp_pc[k], act_pc[k]);
        check_inst(k, exp_inst[k], act_inst[k]);
        check_opcode(k, exp_op[k], act_op[k]);
        check_imm(k, exp_imm[k], act_imm[k]);
      end
    end
    end_test("5 back-pressure", ok, errs);

    $display("retired %0d of %0d, stalls %0d, tests passed %0d, tests failed %0d",
             n_ret, n_exp, stall_cycles, tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
